//--- src/clkPkg.sv
package clkPkg;

  localparam int diagSelWidth = 3;
  localparam int ebusFieldWidth = 4;
  localparam int diagWordWidth = 6;
  localparam int burstWidth = 8;
  localparam int srcWidth = 2;
  localparam int rateWidth = 2;
  localparam int divWidth = 3;  // Holds 2^3 - 1 at the slowest rate

  // Control functions, diagSel under ctlFunc
  localparam logic [diagSelWidth-1:0] funcStop = 3'd0;  // Spare code in hardware
  localparam logic [diagSelWidth-1:0] funcStart = 3'd1;
  localparam logic [diagSelWidth-1:0] funcSingleStep = 3'd2;
  localparam logic [diagSelWidth-1:0] funcBurst = 3'd5;
  localparam logic [diagSelWidth-1:0] funcClrReset = 3'd6;
  localparam logic [diagSelWidth-1:0] funcSetReset = 3'd7;

  // Load functions, diagSel under ldFunc
  localparam logic [diagSelWidth-1:0] ldBurstLow = 3'd2;
  localparam logic [diagSelWidth-1:0] ldBurstHigh = 3'd3;
  localparam logic [diagSelWidth-1:0] ldSourceRate = 3'd4;
  localparam logic [diagSelWidth-1:0] ldDisables = 3'd5;
  localparam logic [diagSelWidth-1:0] ldChecks = 3'd6;
  localparam logic [diagSelWidth-1:0] ldMboxCtl = 3'd7;

  localparam logic [srcWidth-1:0] srcMain = 2'd0;
  localparam logic [srcWidth-1:0] srcExt = 2'd2;

  // Same bus nibble, read per load function
  typedef union packed {
    struct packed {
      logic [srcWidth-1:0] sourceSel;
      logic [rateWidth-1:0] rateSel;
    } sourceRate;
    struct packed {
      logic rsvd;
      logic crmDis;
      logic edpDis;
      logic ctlDis;
    } disables;
    struct packed {
      logic fmParCheck;
      logic cramParCheck;
      logic dramParCheck;
      logic fsCheck;
    } checks;
    struct packed {
      logic mboxCycleDis;
      logic mboxRespSim;
      logic arArxParCheck;
      logic errStopEn;
    } mbox;
  } loadWord_t;

endpackage

//--- src/clkFuncDecode.sv
`timescale 1ns/1ps

module clkFuncDecode (
  input  logic                              CLK,
  input  logic                              reset,
  input  logic                              ctlFunc,
  input  logic                              ldFunc,
  input  logic [clkPkg::diagSelWidth-1:0]   diagSel,
  input  logic [clkPkg::ebusFieldWidth-1:0] ebusField,
  output logic                              startPulse,
  output logic                              stopPulse,
  output logic                              stepPulse,
  output logic                              burstPulse,
  output logic                              clrResetPulse,
  output logic                              setResetPulse,
  output logic                              ldBurstLowPulse,
  output logic                              ldBurstHighPulse,
  output logic                              ldSourceRatePulse,
  output logic                              ldDisablesPulse,
  output logic                              ldChecksPulse,
  output logic                              ldMboxCtlPulse,
  output clkPkg::loadWord_t                 loadField
);

  import clkPkg::*;

  always_ff @(posedge CLK) begin
    if (reset) begin
      startPulse <= 1'b0;
      stopPulse <= 1'b0;
      stepPulse <= 1'b0;
      burstPulse <= 1'b0;
      clrResetPulse <= 1'b0;
      setResetPulse <= 1'b0;
      ldBurstLowPulse <= 1'b0;
      ldBurstHighPulse <= 1'b0;
      ldSourceRatePulse <= 1'b0;
      ldDisablesPulse <= 1'b0;
      ldChecksPulse <= 1'b0;
      ldMboxCtlPulse <= 1'b0;
    end else begin
      // Codes 3 and 4 are ebox SS functions, not modeled
      stopPulse <= ctlFunc && (diagSel == funcStop);
      startPulse <= ctlFunc && (diagSel == funcStart);
      stepPulse <= ctlFunc && (diagSel == funcSingleStep);
      burstPulse <= ctlFunc && (diagSel == funcBurst);
      clrResetPulse <= ctlFunc && (diagSel == funcClrReset);
      setResetPulse <= ctlFunc && (diagSel == funcSetReset);

      ldBurstLowPulse <= ldFunc && (diagSel == ldBurstLow);
      ldBurstHighPulse <= ldFunc && (diagSel == ldBurstHigh);
      ldSourceRatePulse <= ldFunc && (diagSel == ldSourceRate);
      ldDisablesPulse <= ldFunc && (diagSel == ldDisables);
      ldChecksPulse <= ldFunc && (diagSel == ldChecks);
      ldMboxCtlPulse <= ldFunc && (diagSel == ldMboxCtl);
    end
  end

  // Field travels with its load pulse
  always_ff @(posedge CLK) begin
    loadField <= ebusField;
  end

  assert property (@(posedge CLK) disable iff (reset) !(ctlFunc && ldFunc));

  assert property (@(posedge CLK) disable iff (reset)
    $onehot0({startPulse, stopPulse, stepPulse, burstPulse, clrResetPulse,
              setResetPulse, ldBurstLowPulse, ldBurstHighPulse, ldSourceRatePulse,
              ldDisablesPulse, ldChecksPulse, ldMboxCtlPulse}));

endmodule

//--- src/clkConfigRegs.sv
`timescale 1ns/1ps

module clkConfigRegs (
  input  logic                          CLK,
  input  logic                          reset,
  input  logic                          clrResetPulse,
  input  logic                          setResetPulse,
  input  logic                          ldBurstLowPulse,
  input  logic                          ldBurstHighPulse,
  input  logic                          ldSourceRatePulse,
  input  logic                          ldDisablesPulse,
  input  logic                          ldChecksPulse,
  input  logic                          ldMboxCtlPulse,
  input  clkPkg::loadWord_t             loadField,
  output logic [clkPkg::srcWidth-1:0]   sourceSel,
  output logic [clkPkg::rateWidth-1:0]  rateSel,
  output logic [clkPkg::burstWidth-1:0] burstPreset,
  output logic                          crmDis,
  output logic                          edpDis,
  output logic                          ctlDis,
  output logic                          mrReset,
  output logic [3:0]                    parityChecks,
  output logic [3:0]                    mboxCtl
);

  import clkPkg::*;

  // Burst preset nibbles, loaded separately
  always_ff @(posedge CLK) begin
    if (reset) begin
      burstPreset <= '0;
    end else begin
      if (ldBurstLowPulse) burstPreset[3:0] <= loadField;
      if (ldBurstHighPulse) burstPreset[7:4] <= loadField;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      sourceSel <= srcMain;
      rateSel <= '0;
    end else if (ldSourceRatePulse) begin
      sourceSel <= loadField.sourceRate.sourceSel;
      rateSel <= loadField.sourceRate.rateSel;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      crmDis <= 1'b0;
      edpDis <= 1'b0;
      ctlDis <= 1'b0;
    end else if (ldDisablesPulse) begin
      crmDis <= loadField.disables.crmDis;  // Bit 3 is spare
      edpDis <= loadField.disables.edpDis;
      ctlDis <= loadField.disables.ctlDis;
    end
  end

  // Stored only, the checkers themselves are not modeled
  always_ff @(posedge CLK) begin
    if (reset) begin
      parityChecks <= '0;
      mboxCtl <= '0;
    end else begin
      if (ldChecksPulse) parityChecks <= loadField.checks;
      if (ldMboxCtlPulse) mboxCtl <= loadField.mbox;
    end
  end

  // Master reset comes up set
  always_ff @(posedge CLK) begin
    if (reset) begin
      mrReset <= 1'b1;
    end else if (setResetPulse) begin
      mrReset <= 1'b1;
    end else if (clrResetPulse) begin
      mrReset <= 1'b0;
    end
  end

  assert property (@(posedge CLK) disable iff (reset) !(clrResetPulse && setResetPulse));

endmodule

//--- src/clkGateCtl.sv
`timescale 1ns/1ps

module clkGateCtl (
  input  logic                          CLK,
  input  logic                          reset,
  input  logic                          startPulse,
  input  logic                          stopPulse,
  input  logic                          stepPulse,
  input  logic                          burstPulse,
  input  logic                          extTick,
  input  logic                          altTick,
  input  logic [clkPkg::srcWidth-1:0]   sourceSel,
  input  logic [clkPkg::rateWidth-1:0]  rateSel,
  input  logic [clkPkg::burstWidth-1:0] burstPreset,
  input  logic                          crmDis,
  input  logic                          edpDis,
  input  logic                          ctlDis,
  output logic                          eboxClkEn,
  output logic                          crmClkEn,
  output logic                          edpClkEn,
  output logic                          ctlClkEn,
  output logic                          go,
  output logic                          burstRun,
  output logic [clkPkg::burstWidth-1:0] burstCount
);

  import clkPkg::*;

  logic sourceTick;
  logic rateTick;
  logic [divWidth-1:0] divCount;
  logic [divWidth-1:0] divReload;
  logic stepArmed;
  logic burstLive;
  logic enableNow;

  // Odd codes take the alternate tick
  always_comb begin
    if (sourceSel[0]) begin
      sourceTick = altTick;
    end else if (sourceSel == srcExt) begin
      sourceTick = extTick;
    end else begin
      sourceTick = 1'b1;  // Main, every CLK
    end
  end

  assign divReload = divWidth'((1 << rateSel) - 1);
  assign rateTick = sourceTick && (divCount == '0);

  always_ff @(posedge CLK) begin
    if (reset) begin
      divCount <= '0;
    end else if (sourceTick) begin
      divCount <= (divCount == '0) ? divReload : divCount - 1'b1;
    end
  end

  assign burstLive = burstRun && (burstCount != '0);
  assign enableNow = rateTick && (go || stepArmed || burstLive);

  always_ff @(posedge CLK) begin
    if (reset) begin
      go <= 1'b0;
      stepArmed <= 1'b0;
    end else if (stopPulse) begin
      go <= 1'b0;
      stepArmed <= 1'b0;
    end else if (stepPulse) begin
      go <= 1'b0;
      stepArmed <= 1'b1;
    end else begin
      if (startPulse) go <= 1'b1;
      if (rateTick) stepArmed <= 1'b0;  // One enable per step
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      burstRun <= 1'b0;
      burstCount <= '0;
    end else if (stopPulse) begin
      burstRun <= 1'b0;
    end else if (burstPulse) begin
      burstCount <= burstPreset;
      burstRun <= (burstPreset != '0);
    end else if (rateTick && burstLive) begin
      burstCount <= burstCount - 1'b1;
      if (burstCount == 1) burstRun <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      eboxClkEn <= 1'b0;
      crmClkEn <= 1'b0;
      edpClkEn <= 1'b0;
      ctlClkEn <= 1'b0;
    end else begin
      eboxClkEn <= enableNow;
      crmClkEn <= enableNow && !crmDis;
      edpClkEn <= enableNow && !edpDis;
      ctlClkEn <= enableNow && !ctlDis;
    end
  end

  assert property (@(posedge CLK) disable iff (reset)
    (crmClkEn || edpClkEn || ctlClkEn) |-> eboxClkEn);

endmodule

//--- src/clkDiagRead.sv
`timescale 1ns/1ps

module clkDiagRead (
  input  logic                             diagRead,
  input  logic [clkPkg::diagSelWidth-1:0]  diagSel,
  input  logic                             go,
  input  logic                             burstRun,
  input  logic                             mrReset,
  input  logic                             crmDis,
  input  logic                             edpDis,
  input  logic                             ctlDis,
  input  logic [clkPkg::burstWidth-1:0]    burstCount,
  input  logic [clkPkg::srcWidth-1:0]      sourceSel,
  input  logic [clkPkg::rateWidth-1:0]     rateSel,
  input  logic [3:0]                       parityChecks,
  input  logic [3:0]                       mboxCtl,
  output logic [clkPkg::diagWordWidth-1:0] diagData
);

  // Word per select code, zero when not reading
  always_comb begin
    diagData = '0;
    if (diagRead) begin
      case (diagSel)
        3'd0: begin
          diagData = {go, burstRun, mrReset, crmDis, edpDis, ctlDis};
        end
        3'd1: begin
          diagData = {2'b00, burstCount[7:4]};
        end
        3'd2: begin
          diagData = {2'b00, burstCount[3:0]};
        end
        3'd3: begin
          diagData = {2'b00, sourceSel, rateSel};
        end
        3'd4: begin
          diagData = {2'b00, parityChecks};
        end
        3'd5: begin
          diagData = {2'b00, mboxCtl};
        end
        default: begin
          diagData = '0;  // 6 and 7 read back nothing
        end
      endcase
    end
  end

endmodule

//--- src/clkTop.sv
`timescale 1ns/1ps

module clkTop (
  input  logic                              CLK,
  input  logic                              reset,
  input  logic                              ctlFunc,
  input  logic                              ldFunc,
  input  logic [clkPkg::diagSelWidth-1:0]   diagSel,
  input  logic [clkPkg::ebusFieldWidth-1:0] ebusField,
  input  logic                              diagRead,
  input  logic                              extTick,
  input  logic                              altTick,
  output logic                              crmClkEn,
  output logic                              edpClkEn,
  output logic                              ctlClkEn,
  output logic                              eboxClkEn,
  output logic                              mrReset,
  output logic [3:0]                        parityChecks,
  output logic [3:0]                        mboxCtl,
  output logic [clkPkg::diagWordWidth-1:0]  diagData
);

  import clkPkg::*;

  logic startPulse, stopPulse, stepPulse, burstPulse;
  logic clrResetPulse, setResetPulse;
  logic ldBurstLowPulse, ldBurstHighPulse, ldSourceRatePulse;
  logic ldDisablesPulse, ldChecksPulse, ldMboxCtlPulse;
  loadWord_t loadField;
  logic [srcWidth-1:0] sourceSel;
  logic [rateWidth-1:0] rateSel;
  logic [burstWidth-1:0] burstPreset;
  logic [burstWidth-1:0] burstCount;
  logic crmDis, edpDis, ctlDis;
  logic go, burstRun;

  clkFuncDecode i_funcDecode (
    .CLK(CLK), .reset(reset), .ctlFunc(ctlFunc), .ldFunc(ldFunc),
    .diagSel(diagSel), .ebusField(ebusField),
    .startPulse(startPulse), .stopPulse(stopPulse), .stepPulse(stepPulse),
    .burstPulse(burstPulse), .clrResetPulse(clrResetPulse),
    .setResetPulse(setResetPulse), .ldBurstLowPulse(ldBurstLowPulse),
    .ldBurstHighPulse(ldBurstHighPulse), .ldSourceRatePulse(ldSourceRatePulse),
    .ldDisablesPulse(ldDisablesPulse), .ldChecksPulse(ldChecksPulse),
    .ldMboxCtlPulse(ldMboxCtlPulse), .loadField(loadField)
  );

  clkConfigRegs i_configRegs (
    .CLK(CLK), .reset(reset), .clrResetPulse(clrResetPulse),
    .setResetPulse(setResetPulse), .ldBurstLowPulse(ldBurstLowPulse),
    .ldBurstHighPulse(ldBurstHighPulse), .ldSourceRatePulse(ldSourceRatePulse),
    .ldDisablesPulse(ldDisablesPulse), .ldChecksPulse(ldChecksPulse),
    .ldMboxCtlPulse(ldMboxCtlPulse), .loadField(loadField),
    .sourceSel(sourceSel), .rateSel(rateSel), .burstPreset(burstPreset),
    .crmDis(crmDis), .edpDis(edpDis), .ctlDis(ctlDis), .mrReset(mrReset),
    .parityChecks(parityChecks), .mboxCtl(mboxCtl)
  );

  clkGateCtl i_gateCtl (
    .CLK(CLK), .reset(reset), .startPulse(startPulse), .stopPulse(stopPulse),
    .stepPulse(stepPulse), .burstPulse(burstPulse), .extTick(extTick),
    .altTick(altTick), .sourceSel(sourceSel), .rateSel(rateSel),
    .burstPreset(burstPreset), .crmDis(crmDis), .edpDis(edpDis), .ctlDis(ctlDis),
    .eboxClkEn(eboxClkEn), .crmClkEn(crmClkEn), .edpClkEn(edpClkEn),
    .ctlClkEn(ctlClkEn), .go(go), .burstRun(burstRun), .burstCount(burstCount)
  );

  clkDiagRead i_diagRead (
    .diagRead(diagRead), .diagSel(diagSel), .go(go), .burstRun(burstRun),
    .mrReset(mrReset), .crmDis(crmDis), .edpDis(edpDis), .ctlDis(ctlDis),
    .burstCount(burstCount), .sourceSel(sourceSel), .rateSel(rateSel),
    .parityChecks(parityChecks), .mboxCtl(mboxCtl), .diagData(diagData)
  );

endmodule

//--- tests/clkTb.sv
`timescale 1ns/1ps

module clkTb;

  import clkPkg::*;

  logic CLK, reset, ctlFunc, ldFunc, diagRead, extTick, altTick;
  logic [diagSelWidth-1:0] diagSel;
  logic [ebusFieldWidth-1:0] ebusField;
  logic crmClkEn, edpClkEn, ctlClkEn, eboxClkEn, mrReset;
  logic [3:0] parityChecks, mboxCtl;
  logic [diagWordWidth-1:0] diagData;
  logic [31:0] rngState = 32'h617f;

  clkTop i_dut (.*);

  always #5 CLK = ~CLK;

  function logic [31:0] nextRand();
    rngState ^= rngState << 13;
    rngState ^= rngState >> 17;
    rngState ^= rngState << 5;
    return rngState;
  endfunction

  function logic [3:0] randNibble();
    logic [31:0] r;
    r = nextRand();
    return r[3:0];
  endfunction

  task automatic stopRun(input string line);
    $display("%s", line);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else
      stopRun($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task automatic tick();
    @(negedge CLK);
  endtask

  // One-cycle strobe that returns a cycle later
  task automatic ctlStrobe(input logic [2:0] code);
    @(negedge CLK);
    ctlFunc = 1'b1;
    diagSel = code;
    @(negedge CLK);
    ctlFunc = 1'b0;
  endtask

  task automatic loadStrobe(input logic [2:0] code, input logic [3:0] field);
    @(negedge CLK);
    ldFunc = 1'b1;
    diagSel = code;
    ebusField = field;
    @(negedge CLK);
    ldFunc = 1'b0;
  endtask

  task automatic readWord(input logic [2:0] sel, output logic [5:0] data);
    @(negedge CLK);
    diagRead = 1'b1;
    diagSel = sel;
    #1 data = diagData;  // Combinational path
    @(negedge CLK);
    diagRead = 1'b0;
    #1 checkEq("diagData", diagData, 0);  // Idle port reads zero
  endtask

  task automatic countPulses(input int cycles, output int pulses);
    pulses = 0;
    for (int i = 0; i < cycles; i++) begin
      @(negedge CLK);
      if (eboxClkEn) pulses++;
    end
  endtask

  task automatic waitEnable(input int limit, output int cycles);
    bit seen;
    seen = 0;
    cycles = 0;
    for (int n = 1; n <= limit && !seen; n++) begin
      @(negedge CLK);
      if (eboxClkEn) begin
        seen = 1;
        cycles = n;
      end
    end
    if (!seen) stopRun("Timed out waiting for an ebox clock enable pulse");
  endtask

  task automatic driveTicks(input bit useAlt, input int cycles, output int ticks,
                            output int pulses);
    logic [3:0] nib;
    int tail;
    ticks = 0;
    pulses = 0;
    for (int i = 0; i < cycles; i++) begin
      @(negedge CLK);
      if (eboxClkEn) pulses++;
      nib = randNibble();
      extTick = useAlt ? 1'b0 : nib[0];
      altTick = useAlt ? nib[0] : 1'b0;
      if (nib[0]) ticks++;
    end
    @(negedge CLK);
    if (eboxClkEn) pulses++;
    extTick = 1'b0;
    altTick = 1'b0;
    countPulses(4, tail);
    pulses += tail;
  endtask

  task automatic resetReadback();
    logic [5:0] word;
    checkEq("mrReset", mrReset, 1);
    checkEq("clock enables", {eboxClkEn, crmClkEn, edpClkEn, ctlClkEn}, 0);
    readWord(0, word);
    checkEq("diagData sel 0", word, 6'b001000);
    ctlStrobe(funcClrReset);
    checkEq("mrReset", mrReset, 1);  // Still set in the pulse cycle
    tick();
    checkEq("mrReset", mrReset, 0);
    ctlStrobe(funcSetReset);
    tick();
    checkEq("mrReset", mrReset, 1);
  endtask

  task automatic loadReadback();
    loadWord_t lw;
    logic [3:0] hi, lo;
    logic [5:0] word;
    for (int i = 0; i < 4; i++) begin
      lw = randNibble();
      loadStrobe(ldSourceRate, lw);
      readWord(3, word);
      checkEq("diagData sel 3", word,
              {2'b00, lw.sourceRate.sourceSel, lw.sourceRate.rateSel});
      lw = randNibble();
      loadStrobe(ldDisables, lw);
      readWord(0, word);
      checkEq("diagData sel 0", word,
              {3'b001, lw.disables.crmDis, lw.disables.edpDis, lw.disables.ctlDis});
      lw = randNibble();
      loadStrobe(ldChecks, lw);
      readWord(4, word);
      checkEq("diagData sel 4", word, {2'b00, lw.checks});
      checkEq("parityChecks", parityChecks, lw.checks);
      lw = randNibble();
      loadStrobe(ldMboxCtl, lw);
      readWord(5, word);
      checkEq("diagData sel 5", word, {2'b00, lw.mbox});
      checkEq("mboxCtl", mboxCtl, lw.mbox);
      // Idle ext source holds burstCount still
      hi = randNibble();
      lo = randNibble();
      loadStrobe(ldSourceRate, {srcExt, 2'b00});
      loadStrobe(ldBurstLow, lo);
      loadStrobe(ldBurstHigh, hi);
      ctlStrobe(funcBurst);
      readWord(1, word);
      checkEq("diagData sel 1", word, {2'b00, hi});
      readWord(2, word);
      checkEq("diagData sel 2", word, {2'b00, lo});
      ctlStrobe(funcStop);
    end
    loadStrobe(ldDisables, 4'h0);
    readWord(6, word);
    checkEq("diagData sel 6", word, 0);
    readWord(7, word);
    checkEq("diagData sel 7", word, 0);
  endtask

  task automatic rateTest();
    int gap;
    int n;
    for (int r = 0; r < 4; r++) begin
      loadStrobe(ldSourceRate, {srcMain, r[1:0]});
      ctlStrobe(funcStart);
      waitEnable(20, gap);  // First gap may be short
      for (int k = 0; k < 4; k++) begin
        waitEnable(20, gap);
        checkEq("eboxClkEn period", gap, 1 << r);
      end
      ctlStrobe(funcStop);
      tick();
      countPulses(12, n);
      checkEq("eboxClkEn pulses after stop", n, 0);
    end
  endtask

  task automatic stepBurst();
    logic [31:0] r;
    logic [7:0] preset;
    logic [5:0] word;
    int n;
    loadStrobe(ldSourceRate, {srcMain, 2'b00});
    ctlStrobe(funcSingleStep);
    countPulses(20, n);
    checkEq("single step pulse count", n, 1);
    r = nextRand();
    preset = (r[7:0] == 0) ? 8'h5a : r[7:0];
    loadStrobe(ldBurstLow, preset[3:0]);
    loadStrobe(ldBurstHigh, preset[7:4]);
    ctlStrobe(funcBurst);
    countPulses(preset + 30, n);
    checkEq("burst pulse count", n, preset);
    readWord(0, word);
    checkEq("burstRun", word[4], 0);
    readWord(1, word);
    checkEq("diagData sel 1", word, 0);
    loadStrobe(ldBurstLow, 4'h0);
    loadStrobe(ldBurstHigh, 4'h0);
    ctlStrobe(funcBurst);
    countPulses(20, n);
    checkEq("empty burst pulse count", n, 0);
  endtask

  task automatic extAndDisables();
    loadWord_t lw;
    logic [3:0] nib;
    logic [5:0] word;
    int ticks, pulses;
    loadStrobe(ldSourceRate, {srcExt, 2'b00});
    ctlStrobe(funcStart);
    tick();
    driveTicks(0, 40, ticks, pulses);
    checkEq("pulses on extTick", pulses, ticks);
    ctlStrobe(funcStop);
    nib = randNibble();
    loadStrobe(ldSourceRate, {nib[0], 1'b1, 2'b00});  // Odd code picks altTick
    ctlStrobe(funcStart);
    tick();
    driveTicks(1, 40, ticks, pulses);
    checkEq("pulses on altTick", pulses, ticks);
    ctlStrobe(funcStop);
    loadStrobe(ldSourceRate, {srcMain, 2'b00});
    ctlStrobe(funcStart);
    for (int d = 0; d < 8; d++) begin
      nib = randNibble();
      lw = {nib[0], d[2:0]};
      loadStrobe(ldDisables, lw);
      tick();
      for (int k = 0; k < 6; k++) begin
        @(negedge CLK);
        checkEq("eboxClkEn", eboxClkEn, 1);
        checkEq("crmClkEn", crmClkEn, !lw.disables.crmDis);
        checkEq("edpClkEn", edpClkEn, !lw.disables.edpDis);
        checkEq("ctlClkEn", ctlClkEn, !lw.disables.ctlDis);
      end
      readWord(0, word);
      checkEq("diagData sel 0", word, {3'b101, d[2:0]});
    end
    loadStrobe(ldDisables, 4'h0);
    ctlStrobe(funcStop);
  endtask

  initial begin
    CLK = 1'b0;
    reset = 1'b1;
    ctlFunc = 1'b0;
    ldFunc = 1'b0;
    diagSel = '0;
    ebusField = '0;
    diagRead = 1'b0;
    extTick = 1'b0;
    altTick = 1'b0;
    repeat (5) @(negedge CLK);
    reset = 1'b0;
    resetReadback();
    loadReadback();
    rateTest();
    stepBurst();
    extAndDisables();
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- compile.f
src/clkPkg.sv
src/clkFuncDecode.sv
src/clkConfigRegs.sv
src/clkGateCtl.sv
src/clkDiagRead.sv
src/clkTop.sv
tests/clkTb.sv

//--- Bender.yml
package:
  name: clk_ctl

sources:
  - src/clkPkg.sv
  - src/clkFuncDecode.sv
  - src/clkConfigRegs.sv
  - src/clkGateCtl.sv
  - src/clkDiagRead.sv
  - src/clkTop.sv
  - target: test
    files:
      - tests/clkTb.sv
